// ==== design/id_remap_pkg.sv ====
package id_remap_pkg;

  // ID width seen by the upstream master, wide and sparsely used
  localparam int unsigned SlvIdWidth = 6;
  // ID width presented downstream, narrow and densely used
  localparam int unsigned MstIdWidth = 2;
  localparam int unsigned AddrWidth  = 16;
  localparam int unsigned DataWidth  = 16;

  // Defaults for the remap table size and the per-ID in-flight limit
  localparam int unsigned DefMaxUniqIds   = 4;
  localparam int unsigned DefMaxTxnsPerId = 3;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [1:0]            resp_t;

  // Address channel as seen on the slave port, shared by AW and AR
  typedef struct packed {
    slv_id_t              id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } slv_ax_t;

  // Address channel on the master port, only the ID differs
  typedef struct packed {
    mst_id_t              id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } mst_ax_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t              id;
    logic [DataWidth-1:0] data;
    resp_t                resp;
    logic                 last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t              id;
    logic [DataWidth-1:0] data;
    resp_t                resp;
    logic                 last;
  } mst_r_t;

  // Width of a table index for a given entry count, never below one bit
  function automatic int unsigned idx_width(input int unsigned num_idx);
    return (num_idx > 1) ? $clog2(num_idx) : 1;
  endfunction

endpackage

// ==== design/id_remap_table.sv ====
`timescale 1ns/1ps

module id_remap_table import id_remap_pkg::*; #(
  parameter int unsigned MaxUniqIds   = DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = DefMaxTxnsPerId,
  localparam int unsigned IdxWidth    = idx_width(MaxUniqIds)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Lookup of the slave ID currently requesting
  input  slv_id_t             lookup_id_i,
  output logic                exists_o,
  output logic [IdxWidth-1:0] exists_idx_o,
  output logic                exists_full_o,
  // Lowest free entry and the table full flag
  output logic                full_o,
  output logic [IdxWidth-1:0] free_idx_o,
  // Push one transaction into an entry
  input  logic                push_i,
  input  slv_id_t             push_id_i,
  input  logic [IdxWidth-1:0] push_idx_i,
  // Pop one transaction from an entry and read back its slave ID
  input  logic                pop_i,
  input  logic [IdxWidth-1:0] pop_idx_i,
  output slv_id_t             pop_id_o
);

  // The counter must be able to hold MaxTxnsPerId itself
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  typedef logic [CntWidth-1:0]   cnt_t;
  typedef logic [IdxWidth-1:0]   idx_t;
  typedef logic [MaxUniqIds-1:0] field_t;

  // One entry per master index holds the slave ID and its in-flight count
  typedef struct packed {
    slv_id_t id;
    cnt_t    cnt;
  } entry_t;

  entry_t [MaxUniqIds-1:0] table_q, table_d;
  field_t                  free;
  field_t                  match;

  // Priority encoder where the lowest set bit wins
  function automatic idx_t lowest_idx(input field_t vec);
    idx_t idx;
    idx = '0;
    for (int i = MaxUniqIds - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

  // An entry is free once its count has dropped to zero
  // A stale ID left in a free entry never matches
  always_comb begin
    for (int i = 0; i < MaxUniqIds; i++) begin
      free[i]  = (table_q[i].cnt == '0);
      match[i] = !free[i] && (table_q[i].id == lookup_id_i);
    end
  end

  assign full_o       = ~|free;
  assign free_idx_o   = lowest_idx(free);
  assign exists_o     = |match;
  assign exists_idx_o = lowest_idx(match);

  // Only meaningful while exists_o is high
  assign exists_full_o = (table_q[exists_idx_o].cnt == cnt_t'(MaxTxnsPerId));

  // Response path translation back to the slave ID
  assign pop_id_o = table_q[pop_idx_i].id;

  // Push and pop are applied in sequence, so on one entry they cancel
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[push_idx_i].id  = push_id_i;
      table_d[push_idx_i].cnt = table_d[push_idx_i].cnt + cnt_t'(1);
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - cnt_t'(1);
    end
  end

  // Clearing the counts empties the table
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MaxUniqIds; i++) begin
        table_q[i].cnt <= '0;
      end
    end else begin
      table_q <= table_d;
    end
  end

endmodule

// ==== design/ax_remap_ctrl.sv ====
`timescale 1ns/1ps

module ax_remap_ctrl import id_remap_pkg::*; #(
  parameter int unsigned MaxUniqIds = DefMaxUniqIds,
  localparam int unsigned IdxWidth  = idx_width(MaxUniqIds)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Slave side request
  input  logic                slv_valid_i,
  output logic                slv_ready_o,
  input  slv_ax_t             slv_ax_i,
  // Master side request
  output logic                mst_valid_o,
  input  logic                mst_ready_i,
  output mst_ax_t             mst_ax_o,
  // Table status for the requesting slave ID
  input  logic                exists_i,
  input  logic [IdxWidth-1:0] exists_idx_i,
  input  logic                exists_full_i,
  input  logic                full_i,
  input  logic [IdxWidth-1:0] free_idx_i,
  // Table update
  output logic                push_o,
  output logic [IdxWidth-1:0] push_idx_o
);

  typedef enum logic {
    StReady,
    StHold
  } state_e;

  state_e                state_q, state_d;
  logic                  admit;
  logic [IdxWidth-1:0]   new_idx;
  logic [IdxWidth-1:0]   fwd_idx;
  logic [IdxWidth-1:0]   hold_idx_q;

  // A known ID may add a transaction below its limit, a new ID needs a free entry
  assign admit = slv_valid_i && ((exists_i && !exists_full_i) || (!exists_i && !full_i));

  // Reusing the index of a live ID keeps all its bursts in order
  assign new_idx = exists_i ? exists_idx_i : free_idx_i;

  always_comb begin
    state_d     = state_q;
    mst_valid_o = 1'b0;
    push_o      = 1'b0;
    fwd_idx     = new_idx;
    case (state_q)
      StReady: begin
        if (admit) begin
          // The table is updated once here, even when the master stalls
          mst_valid_o = 1'b1;
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            state_d = StHold;
          end
        end
      end
      StHold: begin
        // Keep presenting the index chosen at admission, without pushing again
        fwd_idx     = hold_idx_q;
        mst_valid_o = 1'b1;
        if (mst_ready_i) begin
          state_d = StReady;
        end
      end
      default: state_d = StReady;
    endcase
  end

  // The slave handshake completes in the same cycle as the master one
  assign slv_ready_o = mst_valid_o && mst_ready_i;
  assign push_idx_o  = fwd_idx;

  assign mst_ax_o.id   = mst_id_t'(fwd_idx);
  assign mst_ax_o.addr = slv_ax_i.addr;
  assign mst_ax_o.len  = slv_ax_i.len;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StReady;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the index every ready cycle so it is on hand when a stall begins
  always_ff @(posedge clk_i) begin
    if (state_q == StReady) begin
      hold_idx_q <= new_idx;
    end
  end

endmodule

// ==== design/axi_id_remap.sv ====
`timescale 1ns/1ps

module axi_id_remap import id_remap_pkg::*; #(
  parameter int unsigned MaxUniqIds   = DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = DefMaxTxnsPerId
) (
  input  logic    clk_i,
  input  logic    reset_i,
  // Slave port
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  input  slv_ax_t slv_aw_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  input  slv_ax_t slv_ar_i,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  output slv_b_t  slv_b_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output slv_r_t  slv_r_o,
  // Master port
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  output mst_ax_t mst_aw_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output mst_ax_t mst_ar_o,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  input  mst_b_t  mst_b_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_r_t  mst_r_i
);

  localparam int unsigned IdxWidth = idx_width(MaxUniqIds);

  // Write direction, the AW controller and its table
  logic                wr_exists, wr_exists_full, wr_full, wr_push;
  logic [IdxWidth-1:0] wr_exists_idx, wr_free_idx, wr_push_idx;
  slv_id_t             wr_pop_id;
  // Read direction, the AR controller and its table
  logic                rd_exists, rd_exists_full, rd_full, rd_push;
  logic [IdxWidth-1:0] rd_exists_idx, rd_free_idx, rd_push_idx;
  slv_id_t             rd_pop_id;

  ax_remap_ctrl #(.MaxUniqIds(MaxUniqIds)) u_aw_ctrl (
    .clk_i, .reset_i,
    .slv_valid_i(slv_aw_valid_i), .slv_ready_o(slv_aw_ready_o), .slv_ax_i(slv_aw_i),
    .mst_valid_o(mst_aw_valid_o), .mst_ready_i(mst_aw_ready_i), .mst_ax_o(mst_aw_o),
    .exists_i(wr_exists), .exists_idx_i(wr_exists_idx), .exists_full_i(wr_exists_full),
    .full_i(wr_full), .free_idx_i(wr_free_idx), .push_o(wr_push), .push_idx_o(wr_push_idx)
  );

  // Every accepted B retires one write burst
  id_remap_table #(.MaxUniqIds(MaxUniqIds), .MaxTxnsPerId(MaxTxnsPerId)) u_wr_table (
    .clk_i, .reset_i,
    .lookup_id_i(slv_aw_i.id), .exists_o(wr_exists), .exists_idx_o(wr_exists_idx),
    .exists_full_o(wr_exists_full), .full_o(wr_full), .free_idx_o(wr_free_idx),
    .push_i(wr_push), .push_id_i(slv_aw_i.id), .push_idx_i(wr_push_idx),
    .pop_i(mst_b_valid_i && slv_b_ready_i), .pop_idx_i(mst_b_i.id[IdxWidth-1:0]),
    .pop_id_o(wr_pop_id)
  );

  ax_remap_ctrl #(.MaxUniqIds(MaxUniqIds)) u_ar_ctrl (
    .clk_i, .reset_i,
    .slv_valid_i(slv_ar_valid_i), .slv_ready_o(slv_ar_ready_o), .slv_ax_i(slv_ar_i),
    .mst_valid_o(mst_ar_valid_o), .mst_ready_i(mst_ar_ready_i), .mst_ax_o(mst_ar_o),
    .exists_i(rd_exists), .exists_idx_i(rd_exists_idx), .exists_full_i(rd_exists_full),
    .full_i(rd_full), .free_idx_i(rd_free_idx), .push_o(rd_push), .push_idx_o(rd_push_idx)
  );

  // A read burst is retired only by its last beat
  id_remap_table #(.MaxUniqIds(MaxUniqIds), .MaxTxnsPerId(MaxTxnsPerId)) u_rd_table (
    .clk_i, .reset_i,
    .lookup_id_i(slv_ar_i.id), .exists_o(rd_exists), .exists_idx_o(rd_exists_idx),
    .exists_full_o(rd_exists_full), .full_o(rd_full), .free_idx_o(rd_free_idx),
    .push_i(rd_push), .push_id_i(slv_ar_i.id), .push_idx_i(rd_push_idx),
    .pop_i(mst_r_valid_i && slv_r_ready_i && mst_r_i.last),
    .pop_idx_i(mst_r_i.id[IdxWidth-1:0]), .pop_id_o(rd_pop_id)
  );

  // Responses pass straight through with the ID translated back
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign slv_b_o       = '{id: wr_pop_id, resp: mst_b_i.resp};
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign slv_r_o       = '{id: rd_pop_id, data: mst_r_i.data, resp: mst_r_i.resp,
                           last: mst_r_i.last};

endmodule

// ==== test/axi_id_remap_chk.sv ====
`timescale 1ns/1ps

module axi_id_remap_chk import id_remap_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  // Completed handshakes on each side of every channel
  input logic    slv_aw_xfer_i,
  input logic    mst_aw_xfer_i,
  input logic    slv_ar_xfer_i,
  input logic    mst_ar_xfer_i,
  input logic    slv_b_xfer_i,
  input logic    mst_b_xfer_i,
  input logic    slv_r_xfer_i,
  input logic    mst_r_xfer_i,
  // A stall on a master address channel is valid without ready
  input logic    mst_aw_valid_i,
  input logic    mst_aw_stall_i,
  input mst_id_t mst_aw_id_i,
  input logic    mst_ar_valid_i,
  input logic    mst_ar_stall_i,
  input mst_id_t mst_ar_id_i
);

  // Requests cross in the same cycle on both ports and never on one alone
  a_aw_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_aw_xfer_i == mst_aw_xfer_i) else $error("AW transfers differ on slave and master");
  a_ar_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_ar_xfer_i == mst_ar_xfer_i) else $error("AR transfers differ on slave and master");

  // Responses are pure pass-through
  a_b_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_b_xfer_i |-> slv_b_xfer_i) else $error("master B transfer without slave B");
  a_r_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_r_xfer_i |-> slv_r_xfer_i) else $error("master R transfer without slave R");

  // The held master ID must not move while the downstream stalls
  a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_stall_i |=> (mst_aw_valid_i && $stable(mst_aw_id_i)))
    else $error("stalled master AW dropped valid or changed its ID");
  a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_stall_i |=> (mst_ar_valid_i && $stable(mst_ar_id_i)))
    else $error("stalled master AR dropped valid or changed its ID");

endmodule

bind axi_id_remap axi_id_remap_chk u_chk (
  .clk_i, .reset_i,
  .slv_aw_xfer_i(slv_aw_valid_i && slv_aw_ready_o),
  .mst_aw_xfer_i(mst_aw_valid_o && mst_aw_ready_i),
  .slv_ar_xfer_i(slv_ar_valid_i && slv_ar_ready_o),
  .mst_ar_xfer_i(mst_ar_valid_o && mst_ar_ready_i),
  .slv_b_xfer_i(slv_b_valid_o && slv_b_ready_i),
  .mst_b_xfer_i(mst_b_valid_i && mst_b_ready_o),
  .slv_r_xfer_i(slv_r_valid_o && slv_r_ready_i),
  .mst_r_xfer_i(mst_r_valid_i && mst_r_ready_o),
  .mst_aw_valid_i(mst_aw_valid_o), .mst_aw_stall_i(mst_aw_valid_o && !mst_aw_ready_i),
  .mst_aw_id_i(mst_aw_o.id),
  .mst_ar_valid_i(mst_ar_valid_o), .mst_ar_stall_i(mst_ar_valid_o && !mst_ar_ready_i),
  .mst_ar_id_i(mst_ar_o.id)
);

// ==== test/tb_axi_id_remap.sv ====
`timescale 1ns/1ps

module tb_axi_id_remap import id_remap_pkg::*; ();

  localparam int unsigned ClkPeriodNs   = 8;
  localparam int unsigned NumTests      = 6;
  // The budget per test lies far above the longest test
  localparam int unsigned CyclesPerTest = 400;
  localparam int unsigned WatchdogNs    = NumTests * CyclesPerTest * ClkPeriodNs + 800;
  localparam int unsigned WaitLimit     = 50;

  // The DUT ports connect by name to these signals
  logic    clk_i, reset_i;
  logic    slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  slv_ax_t slv_aw_i, slv_ar_i;
  logic    slv_b_valid_o, slv_b_ready_i, slv_r_valid_o, slv_r_ready_i;
  slv_b_t  slv_b_o;
  slv_r_t  slv_r_o;
  logic    mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  mst_ax_t mst_aw_o, mst_ar_o;
  logic    mst_b_valid_i, mst_b_ready_o, mst_r_valid_i, mst_r_ready_o;
  mst_b_t  mst_b_i;
  mst_r_t  mst_r_i;

  int unsigned checks;
  int unsigned errors;
  int unsigned test_errors;
  logic [15:0] lfsr_q;

  axi_id_remap #(
    .MaxUniqIds(DefMaxUniqIds),
    .MaxTxnsPerId(DefMaxTxnsPerId)
  ) axi_id_remap_i (.*);

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  // Galois LFSR with taps at 16, 14, 13 and 11 that steps once for every bit handed out
  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) begin
        lfsr_q = lfsr_q ^ 16'hB400;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s finished without errors", name);
    end else begin
      $display("Test %s finished with %0d errors", name, test_errors);
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  // Each test starts from empty tables
  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  // Raise valid on AW (wr high) or AR with a random address and length
  task automatic start_ax(input logic wr, input slv_id_t id, output slv_ax_t ax);
    ax.id   = id;
    ax.addr = AddrWidth'(random_bits(AddrWidth));
    ax.len  = 8'(random_bits(8));
    @(posedge clk_i);
    if (wr) begin
      slv_aw_valid_i <= 1'b1;
      slv_aw_i       <= ax;
    end else begin
      slv_ar_valid_i <= 1'b1;
      slv_ar_i       <= ax;
    end
  endtask

  // Wait for the slave handshake, check the remapped request, then drop valid
  task automatic finish_ax(input logic wr, input slv_ax_t ax, input mst_id_t exp_id);
    int unsigned n;
    logic        ready;
    mst_ax_t     got;
    string       port;
    n    = 0;
    port = wr ? "mst_aw_o" : "mst_ar_o";
    do begin
      @(negedge clk_i);
      ready = wr ? slv_aw_ready_o : slv_ar_ready_o;
      n++;
    end while (!ready && n < WaitLimit);
    if (!ready) begin
      $display("Timeout: slave %s ready never rose for ID %0d", wr ? "AW" : "AR", ax.id);
      test_errors++;
    end else begin
      got = wr ? mst_aw_o : mst_ar_o;
      expect_eq({port, ".id"}, 32'(got.id), 32'(exp_id));
      expect_eq({port, ".addr"}, 32'(got.addr), 32'(ax.addr));
      expect_eq({port, ".len"}, 32'(got.len), 32'(ax.len));
    end
    @(posedge clk_i);
    if (wr) begin
      slv_aw_valid_i <= 1'b0;
    end else begin
      slv_ar_valid_i <= 1'b0;
    end
  endtask

  // A refused request keeps both the slave ready and the master valid low
  task automatic expect_stall(input logic wr, input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      if (wr) begin
        expect_eq("slv_aw_ready_o", 32'(slv_aw_ready_o), 32'd0);
        expect_eq("mst_aw_valid_o", 32'(mst_aw_valid_o), 32'd0);
      end else begin
        expect_eq("slv_ar_ready_o", 32'(slv_ar_ready_o), 32'd0);
        expect_eq("mst_ar_valid_o", 32'(mst_ar_valid_o), 32'd0);
      end
    end
  endtask

  // The slave side always accepts a B, so the beat lasts one cycle
  task automatic send_b(input mst_id_t id, input slv_id_t exp_id);
    mst_b_t b;
    b.id   = id;
    b.resp = resp_t'(random_bits(2));
    @(posedge clk_i);
    mst_b_valid_i <= 1'b1;
    mst_b_i       <= b;
    @(negedge clk_i);
    expect_eq("mst_b_ready_o", 32'(mst_b_ready_o), 32'd1);
    expect_eq("slv_b_valid_o", 32'(slv_b_valid_o), 32'd1);
    expect_eq("slv_b_o.id", 32'(slv_b_o.id), 32'(exp_id));
    expect_eq("slv_b_o.resp", 32'(slv_b_o.resp), 32'(b.resp));
    @(posedge clk_i);
    mst_b_valid_i <= 1'b0;
  endtask

  // Drives one R beat with or without last and checks the translated beat
  task automatic send_r(input mst_id_t id, input logic last, input slv_id_t exp_id);
    mst_r_t r;
    r.id   = id;
    r.data = DataWidth'(random_bits(DataWidth));
    r.resp = resp_t'(random_bits(2));
    r.last = last;
    @(posedge clk_i);
    mst_r_valid_i <= 1'b1;
    mst_r_i       <= r;
    @(negedge clk_i);
    expect_eq("mst_r_ready_o", 32'(mst_r_ready_o), 32'd1);
    expect_eq("slv_r_valid_o", 32'(slv_r_valid_o), 32'd1);
    expect_eq("slv_r_o.id", 32'(slv_r_o.id), 32'(exp_id));
    expect_eq("slv_r_o.data", 32'(slv_r_o.data), 32'(r.data));
    expect_eq("slv_r_o.resp", 32'(slv_r_o.resp), 32'(r.resp));
    expect_eq("slv_r_o.last", 32'(slv_r_o.last), 32'(last));
    @(posedge clk_i);
    mst_r_valid_i <= 1'b0;
  endtask

  task automatic allocate_in_order();
    slv_ax_t ax;
    slv_id_t ids [3] = '{6'd5, 6'd9, 6'd40};
    apply_reset();
    foreach (ids[i]) begin
      start_ax(1'b0, ids[i], ax);
      finish_ax(1'b0, ax, mst_id_t'(i));
    end
    report_test("allocation");
  endtask

  task automatic reuse_and_limit();
    slv_ax_t ax;
    apply_reset();
    repeat (3) begin
      start_ax(1'b0, 6'd7, ax);
      finish_ax(1'b0, ax, 2'd0);
    end
    // The fourth burst of ID 7 waits until one of the three retires
    start_ax(1'b0, 6'd7, ax);
    expect_stall(1'b0, 3);
    send_r(2'd0, 1'b1, 6'd7);
    finish_ax(1'b0, ax, 2'd0);
    report_test("reuse and limit");
  endtask

  task automatic translate_responses();
    slv_ax_t ax;
    slv_id_t ids [4] = '{6'd12, 6'd33, 6'd50, 6'd63};
    apply_reset();
    foreach (ids[i]) begin
      start_ax(1'b0, ids[i], ax);
      finish_ax(1'b0, ax, mst_id_t'(i));
    end
    // A beat without last leaves the read table full
    send_r(2'd2, 1'b0, 6'd50);
    start_ax(1'b0, 6'd20, ax);
    expect_stall(1'b0, 3);
    send_r(2'd2, 1'b1, 6'd50);
    finish_ax(1'b0, ax, 2'd2);
    start_ax(1'b1, 6'd17, ax);
    finish_ax(1'b1, ax, 2'd0);
    send_b(2'd0, 6'd17);
    report_test("response translation");
  endtask

  task automatic fill_write_table();
    slv_ax_t ax;
    slv_id_t ids [4] = '{6'd1, 6'd2, 6'd3, 6'd4};
    apply_reset();
    foreach (ids[i]) begin
      start_ax(1'b1, ids[i], ax);
      finish_ax(1'b1, ax, mst_id_t'(i));
    end
    start_ax(1'b1, 6'd60, ax);
    expect_stall(1'b1, 3);
    send_b(2'd1, 6'd2);
    finish_ax(1'b1, ax, 2'd1);
    report_test("table full");
  endtask

  task automatic hold_under_backpressure();
    slv_ax_t ax;
    apply_reset();
    @(posedge clk_i);
    mst_ar_ready_i <= 1'b0;
    start_ax(1'b0, 6'd11, ax);
    repeat (5) begin
      @(negedge clk_i);
      expect_eq("mst_ar_valid_o", 32'(mst_ar_valid_o), 32'd1);
      expect_eq("mst_ar_o.id", 32'(mst_ar_o.id), 32'd0);
      expect_eq("mst_ar_o.addr", 32'(mst_ar_o.addr), 32'(ax.addr));
      expect_eq("slv_ar_ready_o", 32'(slv_ar_ready_o), 32'd0);
    end
    @(posedge clk_i);
    mst_ar_ready_i <= 1'b1;
    // The held burst crosses in the first cycle that sees ready again
    @(negedge clk_i);
    expect_eq("slv_ar_ready_o", 32'(slv_ar_ready_o), 32'd1);
    expect_eq("mst_ar_valid_o", 32'(mst_ar_valid_o), 32'd1);
    expect_eq("mst_ar_o.id", 32'(mst_ar_o.id), 32'd0);
    expect_eq("mst_ar_o.len", 32'(mst_ar_o.len), 32'(ax.len));
    @(posedge clk_i);
    slv_ar_valid_i <= 1'b0;
    @(negedge clk_i);
    expect_eq("mst_ar_valid_o", 32'(mst_ar_valid_o), 32'd0);
    // Two more bursts fit only if the stall pushed the table just once
    repeat (2) begin
      start_ax(1'b0, 6'd11, ax);
      finish_ax(1'b0, ax, 2'd0);
    end
    report_test("back-pressure");
  endtask

  task automatic separate_directions();
    slv_ax_t ax;
    apply_reset();
    // A short AW stall drives the write controller through its hold state too
    @(posedge clk_i);
    mst_aw_ready_i <= 1'b0;
    start_ax(1'b1, 6'd21, ax);
    repeat (2) @(posedge clk_i);
    mst_aw_ready_i <= 1'b1;
    finish_ax(1'b1, ax, 2'd0);
    start_ax(1'b0, 6'd21, ax);
    finish_ax(1'b0, ax, 2'd0);
    send_b(2'd0, 6'd21);
    send_r(2'd0, 1'b1, 6'd21);
    report_test("independent directions");
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns before the tests finished", WatchdogNs);
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    slv_aw_valid_i = 1'b0;
    slv_aw_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_ar_i       = '0;
    slv_b_ready_i  = 1'b1;
    slv_r_ready_i  = 1'b1;
    mst_aw_ready_i = 1'b1;
    mst_ar_ready_i = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_i        = '0;
    mst_r_valid_i  = 1'b0;
    mst_r_i        = '0;
    lfsr_q         = 16'd86;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    allocate_in_order();
    reuse_and_limit();
    translate_responses();
    fill_write_table();
    hold_under_backpressure();
    separate_directions();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
design/id_remap_pkg.sv
design/id_remap_table.sv
design/ax_remap_ctrl.sv
design/axi_id_remap.sv
test/axi_id_remap_chk.sv
test/tb_axi_id_remap.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_axi_id_remap

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" --Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
